/* hw/rvCorePkg.sv */
package rvCorePkg;

    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;

    // RV32I major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011
    } rvOpcode_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASS_B
    } aluOp_e;

    typedef enum logic [1:0] {RS1, PC, ZERO} aluSrc1_e;
    typedef enum logic [1:0] {RS2, IMM, FOUR} aluSrc2_e;

    // Coarse ALU class from decode, refined by funct3/funct7 in execute
    typedef enum logic [1:0] {CLS_ADD, CLS_IMM, CLS_REG, CLS_PASS} aluClass_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} immSel_e;

endpackage

/* hw/fetchStage.sv */
module fetchStage #(
    parameter int imemDepth = 256
) (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic                            run,
    input  logic                            loadValid,
    input  logic [$clog2(imemDepth)-1:0]    loadAddr,
    input  logic [rvCorePkg::XLEN-1:0]      loadData,
    input  logic                            redirect,
    input  logic [rvCorePkg::XLEN-1:0]      redirectPc,
    output logic                            idValid,
    output logic [rvCorePkg::XLEN-1:0]      idPc,
    output logic [rvCorePkg::XLEN-1:0]      idInstr
);
    import rvCorePkg::*;

    localparam int addrW = $clog2(imemDepth);

    logic [XLEN-1:0] imem [imemDepth];
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] fetchInstr;

    // Word indexed, so byte offset bits are dropped
    assign fetchInstr = imem[pc[addrW+1:2]];

    always_ff @(posedge clk) begin
        if (loadValid) begin
            imem[loadAddr] <= loadData;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc      <= '0;
            idValid <= 1'b0;
        end else begin
            // Redirect squashes whatever was fetched this cycle
            idValid <= run && !redirect;
            if (redirect) begin
                pc <= redirectPc;
            end else if (run) begin
                pc <= pc + XLEN'(4);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (run) begin
            idPc    <= pc;
            idInstr <= fetchInstr;
        end
    end

endmodule

/* hw/controlUnit.sv */
module controlUnit (
    input  logic [rvCorePkg::XLEN-1:0]  instr,
    output logic                        jump,
    output logic                        jumpReg,
    output logic                        branch,
    output logic                        regWrite,
    output rvCorePkg::aluSrc1_e         aluSrc1,
    output rvCorePkg::aluSrc2_e         aluSrc2,
    output rvCorePkg::immSel_e          immSel,
    output rvCorePkg::aluClass_e        aluOpClass
);
    import rvCorePkg::*;

    rvOpcode_e opcode;

    assign opcode = rvOpcode_e'(instr[6:0]);

    always_comb begin
        jump       = 1'b0;
        jumpReg    = 1'b0;
        branch     = 1'b0;
        regWrite   = 1'b0;
        aluSrc1    = RS1;
        aluSrc2    = RS2;
        immSel     = IMM_I;
        aluOpClass = CLS_ADD;
        case (opcode)
            OP: begin
                regWrite   = 1'b1;
                aluOpClass = CLS_REG;
            end
            OP_IMM: begin
                regWrite   = 1'b1;
                aluSrc2    = IMM;
                aluOpClass = CLS_IMM;
            end
            LUI: begin
                regWrite   = 1'b1;
                aluSrc1    = ZERO;
                aluSrc2    = IMM;
                immSel     = IMM_U;
                aluOpClass = CLS_PASS;
            end
            AUIPC: begin
                regWrite = 1'b1;
                aluSrc1  = PC;
                aluSrc2  = IMM;
                immSel   = IMM_U;
            end
            // Link value is pc + 4 for both jumps
            JAL: begin
                jump     = 1'b1;
                regWrite = 1'b1;
                aluSrc1  = PC;
                aluSrc2  = FOUR;
                immSel   = IMM_J;
            end
            JALR: begin
                jumpReg  = 1'b1;
                regWrite = 1'b1;
                aluSrc1  = PC;
                aluSrc2  = FOUR;
            end
            BRANCH: begin
                branch = 1'b1;
                immSel = IMM_B;
            end
            default: begin
                // Unknown opcode retires as a no-op
                regWrite = 1'b0;
            end
        endcase
    end

endmodule

/* hw/immExtend.sv */
module immExtend (
    input  logic [rvCorePkg::XLEN-1:0] instr,
    output logic [rvCorePkg::XLEN-1:0] immI,
    output logic [rvCorePkg::XLEN-1:0] immS,
    output logic [rvCorePkg::XLEN-1:0] immB,
    output logic [rvCorePkg::XLEN-1:0] immU,
    output logic [rvCorePkg::XLEN-1:0] immJ
);
    import rvCorePkg::*;

    logic signBit;

    assign signBit = instr[XLEN-1];

    assign immI = {{20{signBit}}, instr[31:20]};
    assign immS = {{20{signBit}}, instr[31:25], instr[11:7]};

    // Branch and jump offsets are in half-words
    assign immB = {{19{signBit}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immJ = {{11{signBit}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign immU = {instr[31:12], 12'b0};

endmodule

/* hw/regFile.sv */
module regFile (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic [rvCorePkg::REG_ADDR_W-1:0]    rs1,
    input  logic [rvCorePkg::REG_ADDR_W-1:0]    rs2,
    input  logic                                wbEn,
    input  logic [rvCorePkg::REG_ADDR_W-1:0]    wbRd,
    input  logic [rvCorePkg::XLEN-1:0]          wbData,
    output logic [rvCorePkg::XLEN-1:0]          rs1Data,
    output logic [rvCorePkg::XLEN-1:0]          rs2Data
);
    import rvCorePkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && wbRd != '0) begin
            regs[wbRd] <= wbData;
        end
    end

    // Write-first bypass doubles as the execute to decode forward
    assign rs1Data = (wbEn && wbRd == rs1 && rs1 != '0) ? wbData : regs[rs1];
    assign rs2Data = (wbEn && wbRd == rs2 && rs2 != '0) ? wbData : regs[rs2];

endmodule

/* hw/branchUnit.sv */
module branchUnit (
    input  logic                        idValid,
    input  logic [rvCorePkg::XLEN-1:0]  idPc,
    input  logic [2:0]                  funct3,
    input  logic [rvCorePkg::XLEN-1:0]  rs1Data,
    input  logic [rvCorePkg::XLEN-1:0]  rs2Data,
    input  logic [rvCorePkg::XLEN-1:0]  immI,
    input  logic [rvCorePkg::XLEN-1:0]  immB,
    input  logic [rvCorePkg::XLEN-1:0]  immJ,
    input  logic                        jump,
    input  logic                        jumpReg,
    input  logic                        branch,
    output logic                        redirect,
    output logic [rvCorePkg::XLEN-1:0]  redirectPc
);
    import rvCorePkg::*;

    logic taken;
    logic [XLEN-1:0] regTarget;

    always_comb begin
        case (funct3)
            3'b000:  taken = rs1Data == rs2Data;
            3'b001:  taken = rs1Data != rs2Data;
            3'b100:  taken = $signed(rs1Data) < $signed(rs2Data);
            3'b101:  taken = $signed(rs1Data) >= $signed(rs2Data);
            3'b110:  taken = rs1Data < rs2Data;
            3'b111:  taken = rs1Data >= rs2Data;
            default: taken = 1'b0;
        endcase
    end

    assign regTarget = rs1Data + immI;

    always_comb begin
        if (jumpReg) begin
            redirectPc = {regTarget[XLEN-1:1], 1'b0};
        end else if (jump) begin
            redirectPc = idPc + immJ;
        end else begin
            redirectPc = idPc + immB;
        end
    end

    assign redirect = idValid && (jump || jumpReg || (branch && taken));

endmodule

/* hw/executeStage.sv */
module executeStage (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic                                idValid,
    input  logic [rvCorePkg::XLEN-1:0]          idPc,
    input  logic [rvCorePkg::XLEN-1:0]          rs1Data,
    input  logic [rvCorePkg::XLEN-1:0]          rs2Data,
    input  logic [rvCorePkg::XLEN-1:0]          imm,
    input  logic [rvCorePkg::REG_ADDR_W-1:0]    rd,
    input  logic [2:0]                          funct3,
    input  logic [6:0]                          funct7,
    input  logic                                regWrite,
    input  rvCorePkg::aluSrc1_e                 aluSrc1,
    input  rvCorePkg::aluSrc2_e                 aluSrc2,
    input  rvCorePkg::aluClass_e                aluOpClass,
    output logic                                wbEn,
    output logic [rvCorePkg::REG_ADDR_W-1:0]    wbRd,
    output logic [rvCorePkg::XLEN-1:0]          wbData,
    output logic                                retireValid,
    output logic [rvCorePkg::XLEN-1:0]          retirePc,
    output logic [rvCorePkg::REG_ADDR_W-1:0]    retireRd,
    output logic [rvCorePkg::XLEN-1:0]          retireData
);
    import rvCorePkg::*;

    logic exValid;
    logic [XLEN-1:0] exPc, exRs1, exRs2, exImm;
    logic [REG_ADDR_W-1:0] exRd;
    logic [2:0] exFunct3;
    logic [6:0] exFunct7;
    logic exRegWrite;
    aluSrc1_e exSrc1;
    aluSrc2_e exSrc2;
    aluClass_e exClass;
    aluOp_e aluOp;
    logic [XLEN-1:0] opA, opB, result;
    logic [4:0] shamt;
    logic writesRd;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exValid <= 1'b0;
        end else begin
            exValid <= idValid;
        end
    end

    always_ff @(posedge clk) begin
        if (idValid) begin
            exPc       <= idPc;
            exRs1      <= rs1Data;
            exRs2      <= rs2Data;
            exImm      <= imm;
            exRd       <= rd;
            exFunct3   <= funct3;
            exFunct7   <= funct7;
            exRegWrite <= regWrite;
            exSrc1     <= aluSrc1;
            exSrc2     <= aluSrc2;
            exClass    <= aluOpClass;
        end
    end

    always_comb begin
        aluOp = ADD;
        if (exClass == CLS_PASS) begin
            aluOp = PASS_B;
        end else if (exClass != CLS_ADD) begin
            case (exFunct3)
                // Immediate forms have no SUB
                3'b000:  aluOp = (exClass == CLS_REG && exFunct7[5]) ? SUB : ADD;
                3'b001:  aluOp = SLL;
                3'b010:  aluOp = SLT;
                3'b011:  aluOp = SLTU;
                3'b100:  aluOp = XOR;
                3'b101:  aluOp = exFunct7[5] ? SRA : SRL;
                3'b110:  aluOp = OR;
                default: aluOp = AND;
            endcase
        end
    end

    always_comb begin
        case (exSrc1)
            PC:      opA = exPc;
            ZERO:    opA = '0;
            default: opA = exRs1;
        endcase
        case (exSrc2)
            IMM:     opB = exImm;
            FOUR:    opB = XLEN'(4);
            default: opB = exRs2;
        endcase
    end

    assign shamt = opB[4:0];

    always_comb begin
        case (aluOp)
            SUB:     result = opA - opB;
            SLL:     result = opA << shamt;
            SLT:     result = XLEN'($signed(opA) < $signed(opB));
            SLTU:    result = XLEN'(opA < opB);
            XOR:     result = opA ^ opB;
            SRL:     result = opA >> shamt;
            SRA:     result = $unsigned($signed(opA) >>> shamt);
            OR:      result = opA | opB;
            AND:     result = opA & opB;
            PASS_B:  result = opB;
            default: result = opA + opB;
        endcase
    end

    // Branches and unknown opcodes carry regWrite low, so rd reads as x0
    assign writesRd = exRegWrite && exRd != '0;

    assign wbEn   = exValid && writesRd;
    assign wbRd   = exRd;
    assign wbData = result;

    assign retireValid = exValid;
    assign retirePc    = exPc;
    assign retireRd    = exRegWrite ? exRd : '0;
    assign retireData  = writesRd ? result : '0;

endmodule

/* hw/rvCoreTop.sv */
module rvCoreTop #(
    parameter int imemDepth = 256
) (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic                                run,
    input  logic                                loadValid,
    input  logic [$clog2(imemDepth)-1:0]        loadAddr,
    input  logic [rvCorePkg::XLEN-1:0]          loadData,
    output logic                                retireValid,
    output logic [rvCorePkg::XLEN-1:0]          retirePc,
    output logic [rvCorePkg::REG_ADDR_W-1:0]    retireRd,
    output logic [rvCorePkg::XLEN-1:0]          retireData
);
    import rvCorePkg::*;

    logic idValid;
    logic [XLEN-1:0] idPc, idInstr;
    logic redirect;
    logic [XLEN-1:0] redirectPc;
    logic jump, jumpReg, branch, regWrite;
    aluSrc1_e aluSrc1;
    aluSrc2_e aluSrc2;
    immSel_e immSel;
    aluClass_e aluOpClass;
    logic [XLEN-1:0] immI, immS, immB, immU, immJ, imm;
    logic [XLEN-1:0] rs1Data, rs2Data;
    logic wbEn;
    logic [REG_ADDR_W-1:0] wbRd;
    logic [XLEN-1:0] wbData;

    fetchStage #(
        .imemDepth(imemDepth)
    ) fetchStage_i (
        .clk, .arstN, .run,
        .loadValid, .loadAddr, .loadData,
        .redirect, .redirectPc,
        .idValid, .idPc, .idInstr
    );

    controlUnit controlUnit_i (
        .instr(idInstr),
        .jump, .jumpReg, .branch, .regWrite,
        .aluSrc1, .aluSrc2, .immSel, .aluOpClass
    );

    immExtend immExtend_i (
        .instr(idInstr),
        .immI, .immS, .immB, .immU, .immJ
    );

    always_comb begin
        case (immSel)
            IMM_S:   imm = immS;
            IMM_B:   imm = immB;
            IMM_U:   imm = immU;
            IMM_J:   imm = immJ;
            default: imm = immI;
        endcase
    end

    regFile regFile_i (
        .clk, .arstN,
        .rs1(idInstr[19:15]),
        .rs2(idInstr[24:20]),
        .wbEn, .wbRd, .wbData,
        .rs1Data, .rs2Data
    );

    branchUnit branchUnit_i (
        .idValid, .idPc,
        .funct3(idInstr[14:12]),
        .rs1Data, .rs2Data,
        .immI, .immB, .immJ,
        .jump, .jumpReg, .branch,
        .redirect, .redirectPc
    );

    executeStage executeStage_i (
        .clk, .arstN, .idValid, .idPc,
        .rs1Data, .rs2Data, .imm,
        .rd(idInstr[11:7]),
        .funct3(idInstr[14:12]),
        .funct7(idInstr[31:25]),
        .regWrite, .aluSrc1, .aluSrc2, .aluOpClass,
        .wbEn, .wbRd, .wbData,
        .retireValid, .retirePc, .retireRd, .retireData
    );

endmodule

/* verif/retireChecker.sv */
module retireChecker #(
    parameter int imemDepth = 256
) (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic                            loadValid,
    input  logic [$clog2(imemDepth)-1:0]    loadAddr,
    input  logic [31:0]                     loadData,
    input  logic                            retireValid,
    input  logic [31:0]                     retirePc,
    input  logic [4:0]                      retireRd,
    input  logic [31:0]                     retireData,
    output logic                            testDone,
    output int                              errorCount
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int addrW = $clog2(imemDepth);

    logic [31:0] progMem [imemDepth];
    logic [31:0] mRegs [32];
    logic [31:0] mPc;
    logic [31:0] expPc;
    logic [4:0] expRd;
    logic [31:0] expData;
    logic atLoop;
    logic started;
    logic bubbleNext;

    function automatic logic [31:0] aluRef(logic [2:0] f3, logic alt, logic [31:0] x,
                                           logic [31:0] y);
        logic [4:0] sh;
        sh = y[4:0];
        case (f3)
            3'd0: return alt ? x - y : x + y;
            3'd1: return x << sh;
            3'd2: return (x[31] != y[31]) ? {31'b0, x[31]} : {31'b0, x < y};
            3'd3: return {31'b0, x < y};
            3'd4: return x ^ y;
            // Arithmetic shift fills the vacated top bits with the sign
            3'd5: return alt ? (x >> sh) | ({32{x[31]}} & ~(32'hffff_ffff >> sh)) : x >> sh;
            3'd6: return x | y;
            default: return x & y;
        endcase
    endfunction

    // Steps the model by one instruction and returns 1 on a jump to itself
    function automatic logic stepModel(output logic [31:0] pcOut, output logic [4:0] rdOut,
                                       output logic [31:0] dataOut);
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] iImm;
        logic [31:0] nextPc;
        logic [31:0] res;
        logic [4:0] rd;
        logic [2:0] f3;
        logic wr;
        logic slt;
        logic taken;
        logic loopHit;
        ins = progMem[mPc[addrW+1:2]];
        a = mRegs[ins[19:15]];
        b = mRegs[ins[24:20]];
        iImm = {{20{ins[31]}}, ins[31:20]};
        rd = ins[11:7];
        f3 = ins[14:12];
        nextPc = mPc + 32'd4;
        res = '0;
        wr = 1'b1;
        slt = (a[31] != b[31]) ? a[31] : (a < b);
        taken = 1'b0;
        case (ins[6:0])
            7'h33: res = aluRef(f3, ins[30], a, b);
            7'h13: res = aluRef(f3, ins[30] && f3 == 3'd5, a, iImm);
            7'h37: res = {ins[31:12], 12'h000};
            7'h17: res = mPc + {ins[31:12], 12'h000};
            7'h6f: begin
                res = mPc + 32'd4;
                nextPc = mPc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            7'h67: begin
                res = mPc + 32'd4;
                nextPc = (a + iImm) & ~32'd1;
            end
            7'h63: begin
                wr = 1'b0;
                case (f3)
                    3'd0: taken = a == b;
                    3'd1: taken = a != b;
                    3'd4: taken = slt;
                    3'd5: taken = !slt;
                    3'd6: taken = a < b;
                    3'd7: taken = a >= b;
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    nextPc = mPc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            default: wr = 1'b0;
        endcase
        pcOut = mPc;
        rdOut = wr ? rd : 5'd0;
        dataOut = (wr && rd != 5'd0) ? res : 32'd0;
        if (wr && rd != 5'd0) begin
            mRegs[rd] = res;
        end
        loopHit = nextPc == mPc;
        mPc = nextPc;
        return loopHit;
    endfunction

    task automatic checkValue(string sigName, logic [31:0] expVal, logic [31:0] actVal);
        if (actVal !== expVal) begin
            $display("CHECK FAILED at %0t: %s expected %h, actual %h",
                     $time, sigName, expVal, actVal);
            errorCount++;
        end
    endtask

    // Outputs settle after the rising edge, so compare on the falling one
    always @(negedge clk) begin
        if (loadValid) begin
            progMem[loadAddr] = loadData;
        end
        if (!arstN) begin
            mPc = '0;
            for (int i = 0; i < 32; i++) begin
                mRegs[i] = '0;
            end
            testDone = 1'b0;
            started = 1'b0;
            bubbleNext = 1'b0;
        end else if (!testDone) begin
            // A taken branch or jump leaves one idle retire cycle behind it
            if (started) begin
                checkValue("retireValid", {31'b0, !bubbleNext}, {31'b0, retireValid});
            end
            if (retireValid) begin
                atLoop = stepModel(expPc, expRd, expData);
                checkValue("retirePc", expPc, retirePc);
                checkValue("retireRd", 32'(expRd), 32'(retireRd));
                checkValue("retireData", expData, retireData);
                bubbleNext = mPc != expPc + 32'd4;
                started = 1'b1;
                // Wrong PC means the model lost sync with the core
                if (atLoop || retirePc !== expPc) begin
                    testDone = 1'b1;
                end
            end else begin
                bubbleNext = 1'b0;
            end
        end
    end

endmodule

/* verif/rvCoreTb.sv */
module rvCoreTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int imemDepth = 256;
    localparam int addrW = $clog2(imemDepth);
    localparam int timeoutCycles = 500;
    localparam int opImm = 'h13;
    localparam int opLui = 'h37;
    localparam int opAuipc = 'h17;
    localparam int opJalr = 'h67;

    logic clk;
    logic arstN;
    logic run;
    logic loadValid;
    logic [addrW-1:0] loadAddr;
    logic [31:0] loadData;
    logic retireValid;
    logic [31:0] retirePc;
    logic [4:0] retireRd;
    logic [31:0] retireData;
    logic testDone;
    int errorCount;
    logic [31:0] prog [$];
    logic [31:0] lcgState = 32'd54926;
    int passCount;
    int failCount;

    rvCoreTop #(
        .imemDepth(imemDepth)
    ) rvCoreTop_i (
        .clk, .arstN, .run,
        .loadValid, .loadAddr, .loadData,
        .retireValid, .retirePc, .retireRd, .retireData
    );

    retireChecker #(
        .imemDepth(imemDepth)
    ) retireChecker_i (
        .clk, .arstN,
        .loadValid, .loadAddr, .loadData,
        .retireValid, .retirePc, .retireRd, .retireData,
        .testDone, .errorCount
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Instruction encoders take each field from the low bits of its argument
    function automatic logic [31:0] encodeR(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] encodeI(int imm, int rs1, int f3, int rd, int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] encodeU(int upper, int rd, int op);
        return {upper[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] encodeB(int off, int rs2, int rs1, int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] encodeJ(int off, int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
    endfunction

    function automatic void emit(logic [31:0] word);
        prog.push_back(word);
    endfunction

    // Upper part of the LUI/ADDI pair is rounded for the sign of the low 12 bits
    function automatic void loadConst(int rd, logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        emit(encodeU(int'(upper >> 12), rd, opLui));
        emit(encodeI(int'(value), rd, 0, rd, opImm));
    endfunction

    function automatic void buildRegOps();
        prog.delete();
        // Opposite signs so signed and unsigned compares disagree
        loadConst(1, nextRandom() | 32'h8000_0000);
        loadConst(2, nextRandom() & 32'h7fff_ffff);
        for (int f = 0; f < 8; f++) begin
            emit(encodeR(0, 2, 1, f, 3 + f));
        end
        emit(encodeR('h20, 2, 1, 0, 11));
        emit(encodeR('h20, 2, 1, 5, 12));
        emit(encodeR(0, 1, 2, 2, 13));
        emit(encodeR(0, 1, 2, 3, 14));
        emit(encodeJ(0, 0));
    endfunction

    function automatic void buildImmOps();
        int imm;
        prog.delete();
        loadConst(1, nextRandom());
        for (int f = 0; f < 8; f++) begin
            imm = (f == 1 || f == 5) ? int'(nextRandom() & 32'h1f) : int'(nextRandom());
            emit(encodeI(imm, 1, f, 2 + f, opImm));
        end
        emit(encodeI('h400 | int'(nextRandom() & 32'h1f), 1, 5, 10, opImm));
        emit(encodeU(int'(nextRandom()), 11, opLui));
        emit(encodeU(int'(nextRandom()), 12, opAuipc));
        // Writes to x0, then x0 is read back
        emit(encodeI(int'(nextRandom()), 1, 0, 0, opImm));
        emit(encodeU(int'(nextRandom()), 0, opLui));
        emit(encodeR(0, 0, 1, 0, 13));
        emit(encodeJ(0, 0));
    endfunction

    function automatic void buildChain();
        logic [31:0] pick;
        int f3;
        int alt;
        prog.delete();
        loadConst(1, nextRandom());
        loadConst(2, nextRandom());
        for (int r = 3; r < 16; r++) begin
            pick = nextRandom();
            f3 = int'(pick & 32'h7);
            alt = ((f3 == 0 || f3 == 5) && pick[8]) ? 'h20 : 0;
            emit(encodeR(alt, r - 1, r - 2, f3, r));
        end
        for (int k = 0; k < 4; k++) begin
            emit(encodeI(int'(nextRandom()), 15, 4, 15, opImm));
        end
        emit(encodeR(0, 15, 14, 0, 16));
        emit(encodeJ(0, 0));
    endfunction

    function automatic void buildBranches();
        prog.delete();
        loadConst(1, nextRandom() | 32'h8000_0000);
        loadConst(2, nextRandom() & 32'h7fff_ffff);
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3) begin
                continue;
            end
            // Each ADDI after a branch runs only when it falls through
            emit(encodeB(8, 2, 1, f));
            emit(encodeI(1, 5, 0, 5, opImm));
            emit(encodeB(8, 1, 2, f));
            emit(encodeI(1, 6, 0, 6, opImm));
            emit(encodeI(0, 1, 0, 3, opImm));
            emit(encodeB(8, 1, 3, f));
            emit(encodeI(1, 7, 0, 7, opImm));
        end
        emit(encodeJ(0, 0));
    endfunction

    function automatic void buildJumps();
        int at;
        prog.delete();
        loadConst(1, nextRandom());
        emit(encodeJ(8, 2));
        emit(encodeI(1, 0, 0, 5, opImm));
        // JALR target must drop bit 0 of this odd base address
        at = prog.size();
        emit(encodeI(4 * (at + 3) + 1, 0, 0, 7, opImm));
        emit(encodeI(0, 7, 0, 8, opJalr));
        emit(encodeI(1, 0, 0, 5, opImm));
        at = prog.size();
        emit(encodeI(4 * (at + 3) - 8, 0, 0, 10, opImm));
        emit(encodeI(8, 10, 0, 10, opJalr));
        emit(encodeI(1, 0, 0, 5, opImm));
        // Forward, back, then forward again
        emit(encodeJ(12, 0));
        emit(encodeI(1, 1, 0, 11, opImm));
        emit(encodeJ(8, 0));
        emit(encodeJ(-8, 12));
        emit(encodeJ(0, 0));
    endfunction

    task automatic runTest(input string name);
        int errorsBefore;
        int cycles;
        errorsBefore = errorCount;
        @(posedge clk);
        #1;
        arstN = 1'b0;
        run = 1'b0;
        loadValid = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        arstN = 1'b1;
        foreach (prog[i]) begin
            loadValid = 1'b1;
            loadAddr = addrW'(i);
            loadData = prog[i];
            @(posedge clk);
            #1;
        end
        loadValid = 1'b0;
        run = 1'b1;
        cycles = 0;
        while (!testDone && cycles < timeoutCycles) begin
            @(posedge clk);
            cycles++;
        end
        #1;
        run = 1'b0;
        if (!testDone) begin
            $display("%s: timed out, self-loop not reached in %0d cycles", name, timeoutCycles);
            failCount++;
        end else if (errorCount != errorsBefore) begin
            $display("%s: failed with %0d mismatches", name, errorCount - errorsBefore);
            failCount++;
        end else begin
            $display("%s: passed", name);
            passCount++;
        end
    endtask

    initial begin
        arstN = 1'b0;
        run = 1'b0;
        loadValid = 1'b0;
        loadAddr = '0;
        loadData = '0;
        buildRegOps();
        runTest("R-type ALU ops");
        buildImmOps();
        runTest("I-type, LUI, AUIPC and x0");
        buildChain();
        runTest("dependent chain");
        buildBranches();
        runTest("conditional branches");
        buildJumps();
        runTest("JAL and JALR");
        $display("tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* rvCoreTop.f */
hw/rvCorePkg.sv
hw/fetchStage.sv
hw/controlUnit.sv
hw/immExtend.sv
hw/regFile.sv
hw/branchUnit.sv
hw/executeStage.sv
hw/rvCoreTop.sv
verif/retireChecker.sv
verif/rvCoreTb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --timescale 1ns/1ps --top-module rvCoreTb \
    -f rvCoreTop.f -o rvCoreSim > build.log 2>&1 \
    && ./obj_dir/rvCoreSim > sim.log 2>&1 \
    || { echo "run.sh: build or simulation error, see build.log and sim.log"; }

grep -q "SIMULATION PASSED" sim.log 2>/dev/null && echo "run.sh: passed" && exit 0
echo "run.sh: failed"
exit 1
